/* verilog/roam_pkg.sv */
package roam_pkg;

  typedef logic [9:0] coord_t;    // screen coordinate
  typedef logic [5:0] palette_t;
  typedef logic [7:0] key_t;
  typedef logic [2:0] battle_t;   // elite number 0..4
  typedef logic [47:0] art_row_t; // 8 pixels of 6 bits

  typedef enum logic [1:0] {
    DIR_UP    = 2'd0,
    DIR_DOWN  = 2'd1,
    DIR_LEFT  = 2'd2,
    DIR_RIGHT = 2'd3
  } dir_t;

  typedef enum logic [2:0] {
    MOVE_NONE  = 3'd0,
    MOVE_UP    = 3'd1,
    MOVE_DOWN  = 3'd2,
    MOVE_LEFT  = 3'd3,
    MOVE_RIGHT = 3'd4,
    MOVE_ACT   = 3'd5
  } move_t;

  // keyboard scan codes
  localparam key_t KEY_W     = 8'h1A;
  localparam key_t KEY_A     = 8'h04;
  localparam key_t KEY_S     = 8'h16;
  localparam key_t KEY_D     = 8'h07;
  localparam key_t KEY_ENTER = 8'h28;

  localparam coord_t SPRITE_W = 10'd8;
  localparam coord_t SPRITE_H = 10'd8;
  localparam coord_t MAP_TILE = 10'd8; // map repeats this tile

  // first rows of each art block in the ROM
  localparam logic [6:0] MAP_BASE     = 7'd0;
  localparam logic [6:0] TRAINER_BASE = 7'd8;
  localparam logic [6:0] ELITE_BASE   = 7'd40;

endpackage

/* verilog/key_frame_sync.sv */
`timescale 1ns/1ns

module key_frame_sync (
  input  logic            Clk,
  input  logic            rst,
  input  logic            frame_clk,
  input  roam_pkg::key_t  keycode,
  output logic            frame_tick,
  output roam_pkg::move_t move
);

  logic frame_q;  // sampled vsync
  logic frame_qq; // one sample older

  always_ff @(posedge Clk) begin
    if (rst) begin
      frame_q    <= 1'b0;
      frame_qq   <= 1'b0;
      frame_tick <= 1'b0;
    end else begin
      frame_q    <= frame_clk;
      frame_qq   <= frame_q;
      frame_tick <= frame_q & ~frame_qq; // one cycle pulse on the rising edge
    end
  end

  always_comb begin
    case (keycode)
      roam_pkg::KEY_W:     move = roam_pkg::MOVE_UP;
      roam_pkg::KEY_S:     move = roam_pkg::MOVE_DOWN;
      roam_pkg::KEY_A:     move = roam_pkg::MOVE_LEFT;
      roam_pkg::KEY_D:     move = roam_pkg::MOVE_RIGHT;
      roam_pkg::KEY_ENTER: move = roam_pkg::MOVE_ACT;
      default:             move = roam_pkg::MOVE_NONE;
    endcase
  end

endmodule

/* verilog/trainer_motion.sv */
`timescale 1ns/1ns

module trainer_motion #(
  parameter roam_pkg::coord_t MAP_X   = 10'd300,
  parameter roam_pkg::coord_t MAP_Y   = 10'd100,
  parameter roam_pkg::coord_t MAP_W   = 10'd192,
  parameter roam_pkg::coord_t MAP_H   = 10'd255,
  parameter roam_pkg::coord_t ENEMY_X = 10'd389,
  parameter roam_pkg::coord_t ENEMY_Y = 10'd212,
  parameter roam_pkg::coord_t START_X = 10'd387,
  parameter roam_pkg::coord_t START_Y = 10'd336,
  parameter roam_pkg::coord_t STEP    = 10'd1
) (
  input  logic             Clk,
  input  logic             rst,
  input  logic             is_roam,
  input  logic             frame_tick,
  input  roam_pkg::move_t  move,
  output roam_pkg::coord_t trainer_x,
  output roam_pkg::coord_t trainer_y,
  output roam_pkg::dir_t   trainer_dir,
  output logic             start_battle
);

  localparam roam_pkg::coord_t SW = roam_pkg::SPRITE_W;
  localparam roam_pkg::coord_t SH = roam_pkg::SPRITE_H;

  roam_pkg::dir_t   want_dir;
  logic             dir_cmd;
  logic             blocked;
  logic             lat_x; // within 3 px sideways
  logic             lat_y;
  logic             adjacent;
  roam_pkg::coord_t x_next;
  roam_pkg::coord_t y_next;
  roam_pkg::dir_t   dir_next;

  // trainer box at (ax, ay) against the enemy box
  function automatic logic hits_enemy(input roam_pkg::coord_t ax, input roam_pkg::coord_t ay);
    hits_enemy = !((ax > ENEMY_X + SW - 10'd1) || (ax + SW - 10'd1 < ENEMY_X) ||
                   (ay > ENEMY_Y + SH - 10'd1) || (ay + SH - 10'd1 < ENEMY_Y));
  endfunction

  always_comb begin
    dir_cmd  = 1'b1;
    want_dir = trainer_dir;
    case (move)
      roam_pkg::MOVE_UP:    want_dir = roam_pkg::DIR_UP;
      roam_pkg::MOVE_DOWN:  want_dir = roam_pkg::DIR_DOWN;
      roam_pkg::MOVE_LEFT:  want_dir = roam_pkg::DIR_LEFT;
      roam_pkg::MOVE_RIGHT: want_dir = roam_pkg::DIR_RIGHT;
      default:              dir_cmd = 1'b0;
    endcase
  end

  // border limits and a one pixel probe into the enemy box
  always_comb begin
    case (want_dir)
      roam_pkg::DIR_UP:
        blocked = (trainer_y <= MAP_Y + 10'd25) || hits_enemy(trainer_x, trainer_y - 10'd1);
      roam_pkg::DIR_DOWN:
        blocked = (trainer_y >= MAP_Y + MAP_H - 10'd1 - SH) ||
                  hits_enemy(trainer_x, trainer_y + 10'd1);
      roam_pkg::DIR_LEFT:
        blocked = (trainer_x <= MAP_X) || hits_enemy(trainer_x - 10'd1, trainer_y);
      default:
        blocked = (trainer_x >= MAP_X + MAP_W - 10'd1 - SW) ||
                  hits_enemy(trainer_x + 10'd1, trainer_y);
    endcase
  end

  always_comb begin
    x_next   = trainer_x;
    y_next   = trainer_y;
    dir_next = trainer_dir;
    if (frame_tick && dir_cmd) begin
      if (trainer_dir != want_dir) begin
        dir_next = want_dir; // turn only
      end else if (!blocked) begin
        case (want_dir)
          roam_pkg::DIR_UP:   y_next = trainer_y - STEP;
          roam_pkg::DIR_DOWN: y_next = trainer_y + STEP;
          roam_pkg::DIR_LEFT: x_next = trainer_x - STEP;
          default:            x_next = trainer_x + STEP;
        endcase
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (rst || !is_roam) begin
      trainer_x   <= START_X;
      trainer_y   <= START_Y;
      trainer_dir <= roam_pkg::DIR_UP;
    end else begin
      trainer_x   <= x_next;
      trainer_y   <= y_next;
      trainer_dir <= dir_next;
    end
  end

  // facing side must sit 0..3 px from the enemy edge
  always_comb begin
    lat_x = (trainer_x + 10'd3 >= ENEMY_X) && (trainer_x <= ENEMY_X + 10'd3);
    lat_y = (trainer_y + 10'd3 >= ENEMY_Y) && (trainer_y <= ENEMY_Y + 10'd3);
    case (trainer_dir)
      roam_pkg::DIR_UP:
        adjacent = lat_x && (trainer_y >= ENEMY_Y + SH) && (trainer_y <= ENEMY_Y + SH + 10'd3);
      roam_pkg::DIR_DOWN:
        adjacent = lat_x && (trainer_y + SH <= ENEMY_Y) && (trainer_y + SH + 10'd3 >= ENEMY_Y);
      roam_pkg::DIR_LEFT:
        adjacent = lat_y && (trainer_x >= ENEMY_X + SW) && (trainer_x <= ENEMY_X + SW + 10'd3);
      default:
        adjacent = lat_y && (trainer_x + SW <= ENEMY_X) && (trainer_x + SW + 10'd3 >= ENEMY_X);
    endcase
  end

  assign start_battle = is_roam && (move == roam_pkg::MOVE_ACT) && adjacent;

endmodule

/* verilog/sprite_rom.sv */
`timescale 1ns/1ns

module sprite_rom (
  input  logic               Clk,
  input  logic [6:0]         addr,
  output roam_pkg::art_row_t row
);

  // map tile, four trainer poses, five elites
  roam_pkg::art_row_t mem [0:79];

  initial begin
    $readmemh("verilog/sprite_art.hex", mem);
  end

  always_ff @(posedge Clk) begin
    row <= mem[addr];
  end

endmodule

/* verilog/sprite_layer.sv */
`timescale 1ns/1ns

module sprite_layer #(
  parameter roam_pkg::coord_t MAP_W = 10'd192,
  parameter roam_pkg::coord_t MAP_H = 10'd255
) (
  input  logic               Clk,
  input  roam_pkg::coord_t   draw_x,
  input  roam_pkg::coord_t   draw_y,
  input  roam_pkg::coord_t   origin_x,
  input  roam_pkg::coord_t   origin_y,
  input  logic [6:0]         base,
  input  logic               wrap,
  output logic               hit,
  output roam_pkg::palette_t color
);

  roam_pkg::coord_t   rel_x;
  roam_pkg::coord_t   rel_y;
  roam_pkg::coord_t   win_w;
  roam_pkg::coord_t   win_h;
  roam_pkg::coord_t   tile_x;
  roam_pkg::coord_t   tile_y;
  logic               in_win;
  logic [6:0]         addr;
  logic [2:0]         col_q; // column, aligned with rom output
  roam_pkg::art_row_t row;

  always_comb begin
    rel_x  = draw_x - origin_x;
    rel_y  = draw_y - origin_y;
    win_w  = wrap ? MAP_W : roam_pkg::SPRITE_W;
    win_h  = wrap ? MAP_H : roam_pkg::SPRITE_H;
    in_win = (draw_x >= origin_x) && (draw_y >= origin_y) && (rel_x < win_w) && (rel_y < win_h);
    tile_x = rel_x % roam_pkg::MAP_TILE; // no-op inside a sprite window
    tile_y = rel_y % roam_pkg::MAP_TILE;
    addr   = base + {4'd0, tile_y[2:0]};
  end

  sprite_rom rom0 (
    .Clk  (Clk),
    .addr (addr),
    .row  (row)
  );

  always_ff @(posedge Clk) begin
    hit   <= in_win;
    col_q <= tile_x[2:0];
  end

  // leftmost pixel sits in the top bits of the row
  assign color = row[(3'd7 - col_q) * 6 +: 6];

endmodule

/* verilog/roam_compositor.sv */
`timescale 1ns/1ns

module roam_compositor #(
  parameter roam_pkg::coord_t MAP_X   = 10'd300,
  parameter roam_pkg::coord_t MAP_Y   = 10'd100,
  parameter roam_pkg::coord_t MAP_W   = 10'd192,
  parameter roam_pkg::coord_t MAP_H   = 10'd255,
  parameter roam_pkg::coord_t ENEMY_X = 10'd389,
  parameter roam_pkg::coord_t ENEMY_Y = 10'd212
) (
  input  logic               Clk,
  input  roam_pkg::coord_t   draw_x,
  input  roam_pkg::coord_t   draw_y,
  input  roam_pkg::coord_t   trainer_x,
  input  roam_pkg::coord_t   trainer_y,
  input  roam_pkg::dir_t     trainer_dir,
  input  roam_pkg::battle_t  cur_battle,
  output roam_pkg::palette_t palette,
  output logic               is_sprite
);

  logic [6:0]         trainer_base;
  logic [6:0]         elite_base;
  logic               map_hit, trainer_hit, elite_hit;
  roam_pkg::palette_t map_color, trainer_color, elite_color;

  assign trainer_base = roam_pkg::TRAINER_BASE + {2'b00, trainer_dir, 3'b000}; // 8 rows per pose
  assign elite_base   = roam_pkg::ELITE_BASE + {1'b0, cur_battle, 3'b000};

  sprite_layer #(.MAP_W(MAP_W), .MAP_H(MAP_H)) map_layer0 (
    .Clk(Clk), .draw_x(draw_x), .draw_y(draw_y), .origin_x(MAP_X), .origin_y(MAP_Y),
    .base(roam_pkg::MAP_BASE), .wrap(1'b1), .hit(map_hit), .color(map_color)
  );

  sprite_layer #(.MAP_W(MAP_W), .MAP_H(MAP_H)) trainer_layer0 (
    .Clk(Clk), .draw_x(draw_x), .draw_y(draw_y), .origin_x(trainer_x), .origin_y(trainer_y),
    .base(trainer_base), .wrap(1'b0), .hit(trainer_hit), .color(trainer_color)
  );

  sprite_layer #(.MAP_W(MAP_W), .MAP_H(MAP_H)) elite_layer0 (
    .Clk(Clk), .draw_x(draw_x), .draw_y(draw_y), .origin_x(ENEMY_X), .origin_y(ENEMY_Y),
    .base(elite_base), .wrap(1'b0), .hit(elite_hit), .color(elite_color)
  );

  // elite over trainer over map and colour 0 lets the map through
  always_comb begin
    is_sprite = 1'b1;
    if (elite_hit) begin
      palette = (elite_color == 6'd0) ? map_color : elite_color;
    end else if (trainer_hit) begin
      palette = (trainer_color == 6'd0) ? map_color : trainer_color;
    end else if (map_hit) begin
      palette = map_color;
    end else begin
      palette   = 6'd1;
      is_sprite = 1'b0;
    end
  end

endmodule

/* verilog/roam_top.sv */
`timescale 1ns/1ns

module roam_top #(
  parameter roam_pkg::coord_t MAP_X   = 10'd300,
  parameter roam_pkg::coord_t MAP_Y   = 10'd100,
  parameter roam_pkg::coord_t MAP_W   = 10'd192,
  parameter roam_pkg::coord_t MAP_H   = 10'd255,
  parameter roam_pkg::coord_t ENEMY_X = 10'd389,
  parameter roam_pkg::coord_t ENEMY_Y = 10'd212,
  parameter roam_pkg::coord_t START_X = 10'd387,
  parameter roam_pkg::coord_t START_Y = 10'd336,
  parameter roam_pkg::coord_t STEP    = 10'd1
) (
  input  logic               Clk,
  input  logic               rst,
  input  logic               frame_clk,    // raw vsync level
  input  roam_pkg::key_t     keycode,
  input  logic               is_roam,
  input  roam_pkg::battle_t  cur_battle,
  input  roam_pkg::coord_t   draw_x,
  input  roam_pkg::coord_t   draw_y,
  output roam_pkg::palette_t palette,
  output logic               is_sprite,
  output logic               start_battle,
  output roam_pkg::coord_t   trainer_x,
  output roam_pkg::coord_t   trainer_y,
  output roam_pkg::dir_t     trainer_dir
);

  logic            frame_tick;
  roam_pkg::move_t move;

  key_frame_sync sync0 (
    .Clk(Clk), .rst(rst), .frame_clk(frame_clk), .keycode(keycode),
    .frame_tick(frame_tick), .move(move)
  );

  trainer_motion #(
    .MAP_X(MAP_X), .MAP_Y(MAP_Y), .MAP_W(MAP_W), .MAP_H(MAP_H),
    .ENEMY_X(ENEMY_X), .ENEMY_Y(ENEMY_Y),
    .START_X(START_X), .START_Y(START_Y), .STEP(STEP)
  ) motion0 (
    .Clk(Clk), .rst(rst), .is_roam(is_roam), .frame_tick(frame_tick), .move(move),
    .trainer_x(trainer_x), .trainer_y(trainer_y), .trainer_dir(trainer_dir),
    .start_battle(start_battle)
  );

  roam_compositor #(
    .MAP_X(MAP_X), .MAP_Y(MAP_Y), .MAP_W(MAP_W), .MAP_H(MAP_H),
    .ENEMY_X(ENEMY_X), .ENEMY_Y(ENEMY_Y)
  ) comp0 (
    .Clk(Clk), .draw_x(draw_x), .draw_y(draw_y),
    .trainer_x(trainer_x), .trainer_y(trainer_y), .trainer_dir(trainer_dir),
    .cur_battle(cur_battle), .palette(palette), .is_sprite(is_sprite)
  );

endmodule

/* test/roam_tb.sv */
`timescale 1ns/1ns

module roam_tb;

  localparam roam_pkg::coord_t START_X = 10'd387;
  localparam roam_pkg::coord_t START_Y = 10'd336;

  logic               Clk;
  logic               rst;
  logic               frame_clk;
  roam_pkg::key_t     keycode;
  logic               is_roam;
  roam_pkg::battle_t  cur_battle;
  roam_pkg::coord_t   draw_x;
  roam_pkg::coord_t   draw_y;
  roam_pkg::palette_t palette;
  logic               is_sprite;
  logic               start_battle;
  roam_pkg::coord_t   trainer_x;
  roam_pkg::coord_t   trainer_y;
  roam_pkg::dir_t     trainer_dir;

  int   errors = 0;
  int   test_errors = 0; // failures inside the current test
  int   tests_passed = 0;
  int   tests_failed = 0;
  int   trace_lines = 0;
  int   trace_ticks = 0;
  logic trace_ready = 1'b0;
  logic pend_valid = 1'b0; // pixel query in flight
  int   pend_palette;
  int   pend_sprite;

  roam_top dut0 (
    .Clk(Clk), .rst(rst), .frame_clk(frame_clk), .keycode(keycode), .is_roam(is_roam),
    .cur_battle(cur_battle), .draw_x(draw_x), .draw_y(draw_y), .palette(palette),
    .is_sprite(is_sprite), .start_battle(start_battle), .trainer_x(trainer_x),
    .trainer_y(trainer_y), .trainer_dir(trainer_dir)
  );

  always #10 Clk = ~Clk;

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, sig, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  // returns 2 ns after the edge and checks the pixel in flight
  task automatic next_cycle;
    @(posedge Clk);
    #2;
    if (pend_valid) begin
      pend_valid = 1'b0;
      if (palette !== pend_palette[5:0]) report_mismatch("palette", pend_palette, palette);
      if (is_sprite !== pend_sprite[0]) report_mismatch("is_sprite", pend_sprite, is_sprite);
    end
  endtask

  task automatic press_for_ticks(input int key, input int n);
    repeat (n) begin
      next_cycle();
      keycode   = key[7:0];
      frame_clk = 1'b1; // one cycle high, three low
      next_cycle();
      frame_clk = 1'b0;
      next_cycle();
      next_cycle();
    end
  endtask

  task automatic close_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: pass", name);
      tests_passed++;
    end else begin
      $display("test %s: fail, %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic apply_line(input logic [7:0] op, input int a, b, c, d, e, input string name);
    case (op)
      "R": begin
        next_cycle();
        is_roam = a[0];
      end
      "K": press_for_ticks(a, b);
      "T": begin
        next_cycle();
        if (trainer_x !== a[9:0]) report_mismatch("trainer_x", a, trainer_x);
        if (trainer_y !== b[9:0]) report_mismatch("trainer_y", b, trainer_y);
        if (trainer_dir !== c[1:0]) report_mismatch("trainer_dir", c, trainer_dir);
      end
      "B": begin
        next_cycle();
        keycode = a[7:0];
        #5; // start_battle is combinational
        if (start_battle !== b[0]) report_mismatch("start_battle", b, start_battle);
      end
      "P": begin
        next_cycle();
        draw_x       = a[9:0];
        draw_y       = b[9:0];
        cur_battle   = c[2:0];
        pend_palette = d;
        pend_sprite  = e;
        pend_valid   = 1'b1;
      end
      default: begin
        next_cycle();
        close_test(name);
      end
    endcase
  endtask

  // dry pass only counts lines and ticks
  task automatic run_trace(input bit dry);
    int               fd;
    int               code;
    int               need;
    int               a, b, c, d, e;
    logic [7:0]       op;
    logic [8*128-1:0] skip;
    string            name;
    logic             done;
    fd = $fopen("test/roam_trace.txt", "r");
    if (fd == 0) begin
      if (!dry) report_problem("could not open the trace file test/roam_trace.txt");
      return;
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", op);
      need = 0;
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        code = $fgets(skip, fd);
      end else begin
        case (op)
          "R": begin
            need = 1;
            code = $fscanf(fd, "%d", a);
          end
          "K", "B": begin
            need = 2;
            code = $fscanf(fd, "%h %d", a, b);
          end
          "T": begin
            need = 3;
            code = $fscanf(fd, "%d %d %d", a, b, c);
          end
          "P": begin
            need = 5;
            code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
          end
          "E": begin
            need = 1;
            code = $fscanf(fd, "%s", name);
          end
          default: code = -1;
        endcase
        if (code != need) begin
          if (!dry) report_problem("the trace file holds a malformed or unknown line");
          done = 1'b1;
        end else if (dry) begin
          trace_lines++;
          if (op == "K") trace_ticks += b;
        end else begin
          apply_line(op, a, b, c, d, e, name);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (trace_ready);
    #((trace_lines * 40 + trace_ticks * 8 + 100) * 20);
    $display("watchdog expired, the trace did not finish in time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    Clk        = 1'b0;
    rst        = 1'b1;
    frame_clk  = 1'b0;
    keycode    = 8'h00;
    is_roam    = 1'b0;
    cur_battle = 3'd0;
    draw_x     = 10'd0;
    draw_y     = 10'd0;
    run_trace(1'b1);
    trace_ready = 1'b1;
    repeat (5) @(posedge Clk);
    #2;
    rst = 1'b0;
    next_cycle();
    if (trainer_x !== START_X) report_mismatch("trainer_x", START_X, trainer_x);
    if (trainer_y !== START_Y) report_mismatch("trainer_y", START_Y, trainer_y);
    if (trainer_dir !== roam_pkg::DIR_UP) report_mismatch("trainer_dir", 0, trainer_dir);
    if (start_battle !== 1'b0) report_mismatch("start_battle", 0, start_battle);
    if (is_sprite !== 1'b0) report_mismatch("is_sprite", 0, is_sprite);
    close_test("after_reset");
    run_trace(1'b0);
    $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/roam_pkg.sv
verilog/key_frame_sync.sv
verilog/trainer_motion.sv
verilog/sprite_rom.sv
verilog/sprite_layer.sv
verilog/roam_compositor.sv
verilog/roam_top.sv
test/roam_tb.sv

/* verilog/sprite_art.hex */
208208208208
249249249249
28a28a28a28a
2cb2cb2cb2cb
30c30c30c30c
34d34d34d34d
38e38e38e38e
3cf3cf3cf3cf
010410410400
010410410400
010410410400
010410410400
010410410400
010410410400
010410410400
010410410400
011451451440
011451451440
011451451440
011451451440
011451451440
011451451440
011451451440
011451451440
012492492480
012492492480
012492492480
012492492480
012492492480
012492492480
012492492480
012492492480
0134d34d34c0
0134d34d34c0
0134d34d34c0
0134d34d34c0
0134d34d34c0
0134d34d34c0
0134d34d34c0
0134d34d34c0
820820000000
820820000000
820820000000
820820000000
820820000000
820820000000
820820000000
820820000000
861861000000
861861000000
861861000000
861861000000
861861000000
861861000000
861861000000
861861000000
8a28a2000000
8a28a2000000
8a28a2000000
8a28a2000000
8a28a2000000
8a28a2000000
8a28a2000000
8a28a2000000
8e38e3000000
8e38e3000000
8e38e3000000
8e38e3000000
8e38e3000000
8e38e3000000
8e38e3000000
8e38e3000000
924924000000
924924000000
924924000000
924924000000
924924000000
924924000000
924924000000
924924000000

/* test/roam_trace.txt */
# R roam | K key ticks | T x y dir | B key start_battle | E test_name
# P draw_x draw_y cur_battle palette is_sprite ; keys in hex, all else decimal
R 1
T 387 336 0
B 00 0
P 0 0 0 1 0
E roam_start
K 07 1
T 387 336 3
K 07 1
K 55 1
T 388 336 3
E turn_then_step
K 16 16
T 388 346 1
K 04 101
T 300 346 2
K 07 191
K 1a 231
T 483 125 0
E map_borders
K 04 95
K 16 101
T 389 204 1
B 28 1
K 1a 1
B 28 0
K 1a 4
K 16 1
T 389 200 1
B 28 0
E enemy_block
P 391 203 0 17 1
P 389 203 0 15 1
P 390 215 2 34 1
P 394 215 2 11 1
P 392 212 4 36 1
P 491 354 0 14 1
P 299 150 0 1 0
P 400 355 0 1 0
E pixels
R 0
R 1
T 387 336 0
E leave_roam
